// File: sam_pkg.sv
// ==========================================================
// Shared constants and types for the SAM I/O and paging core
// Port addresses are matched on the low address byte only
// Physical addresses above the used page bits read as zero
// ==========================================================

package sam_pkg;

	// ======================================================
	// I/O port addresses (low byte)
	// ======================================================
	localparam logic [7:0] PORT_EXT_C      = 8'h80;
	localparam logic [7:0] PORT_EXT_D      = 8'h81;
	localparam logic [7:0] PORT_LPT_DATA   = 8'hE8;
	localparam logic [7:0] PORT_LPT_STROBE = 8'hE9;
	localparam logic [7:0] PORT_STATUS     = 8'hF9;
	localparam logic [7:0] PORT_LMPR       = 8'hFA;
	localparam logic [7:0] PORT_HMPR       = 8'hFB;
	localparam logic [7:0] PORT_MIDI       = 8'hFD;
	localparam logic [7:0] PORT_BORDER     = 8'hFE;

	// ======================================================
	// Memory map
	// ======================================================
	localparam int MEM_ADDR_W = 25;
	localparam int PAGE_W     = 5;
	localparam int SECT_W     = 14;                 // 16 KB section offset
	localparam int TOP_W      = MEM_ADDR_W - SECT_W;  // Bits above the section offset

	localparam logic [PAGE_W-1:0] ROM_PAGE     = 5'h10;
	localparam logic [8:0]        EXT_RAM_BASE = 9'h040;

	// MIDI timing, 96 MHz system clock assumed
	localparam int CE_1M_DIV        = 96;
	localparam int CE_1M_W          = $clog2(CE_1M_DIV);
	localparam int MIDI_FRAME_TICKS = 320;
	localparam int MIDI_TIMER_W     = $clog2(MIDI_FRAME_TICKS);
	localparam int MIDI_INT_TICK    = 15;

	// Audio mix
	localparam int DAC_W       = 19;
	localparam int VOX_GAIN    = 1028;    // Byte spread over the upper bits
	localparam int BEEP_WEIGHT = 65536;

	typedef enum logic [3:0] {
		NONE,
		EXT_C,
		EXT_D,
		LPT_DATA,
		LPT_STROBE,
		STATUS,
		LMPR,
		HMPR,
		MIDI,
		BORDER
	} port_sel_e;

	// CPU bus, strobes already active high
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  dout;
		logic        mreq;
		logic        iorq;
		logic        rd;
		logic        wr;
		logic        m1;
	} cpu_bus_t;

	// Single-cycle port write event
	typedef struct packed {
		logic      valid;
		port_sel_e sel;
		logic [7:0] data;
	} io_wr_t;

	typedef struct packed {
		logic [PAGE_W-1:0] page_ab;
		logic              rom0_off;
		logic              rom1_on;
		logic              wp_a;
		logic [PAGE_W-1:0] page_cd;
		logic              ext_on;
		logic [7:0]        ext_c;
		logic [7:0]        ext_d;
	} page_state_t;

	typedef struct packed {
		logic [MEM_ADDR_W-1:0] addr;
		logic                  rd;
		logic                  we;
		logic                  is_rom;
	} mem_req_t;

endpackage

// File: sigma_delta_dac.sv
// ==========================================================
// First-order sigma-delta DAC, unsigned input
// Ones density is sample / 2^WIDTH, exact over 2^WIDTH clocks
// ==========================================================

`timescale 1ns/1ps

module sigma_delta_dac import sam_pkg::*; #(
	parameter int WIDTH = DAC_W
) (
	input  logic             clk_sys,
	input  logic             reset,
	input  logic [WIDTH-1:0] sample,
	output logic             dac_out
);

	logic [WIDTH:0] acc;   // Top bit is the carry out

	always_ff @(posedge clk_sys) begin
		if (reset)
			acc <= '0;
		else
			acc <= {1'b0, acc[WIDTH-1:0]} + {1'b0, sample};
	end

	assign dac_out = acc[WIDTH];

endmodule

// File: port_regs.sv
// ==========================================================
// Port decoder and ASIC registers
// Writes act once per strobe, on its rising edge
// Read data is combinational, io_dout_en only for ports 0xE8,
// 0xE9, 0xF9, 0xFA and 0xFB
// ==========================================================

`timescale 1ns/1ps

module port_regs import sam_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  cpu_bus_t    bus,
	input  logic        midi_int,
	output io_wr_t      io_wr,
	output page_state_t pages,
	output logic        beep,
	output logic [7:0]  io_dout,
	output logic        io_dout_en
);

	port_sel_e  sel;
	logic       port_we;
	logic       port_rd;
	logic       port_we_d;
	logic       wr_edge;
	logic       readable;

	logic       wr_valid;
	port_sel_e  wr_sel;
	logic [7:0] wr_data;

	logic [7:0] lmpr;
	logic [7:0] hmpr;
	logic [7:0] brdr;
	logic [7:0] ext_c;
	logic [7:0] ext_d;

	// ======================================================
	// Decode
	// ======================================================
	assign port_we = bus.iorq & bus.wr & ~bus.m1;
	assign port_rd = bus.iorq & bus.rd & ~bus.m1;
	assign wr_edge = port_we & ~port_we_d;

	always_comb begin
		case (bus.addr[7:0])
			PORT_EXT_C:      sel = EXT_C;
			PORT_EXT_D:      sel = EXT_D;
			PORT_LPT_DATA:   sel = LPT_DATA;
			PORT_LPT_STROBE: sel = LPT_STROBE;
			PORT_STATUS:     sel = STATUS;
			PORT_LMPR:       sel = LMPR;
			PORT_HMPR:       sel = HMPR;
			PORT_MIDI:       sel = MIDI;
			PORT_BORDER:     sel = BORDER;
			default:         sel = NONE;
		endcase
	end

	// ======================================================
	// Registers and write event
	// ======================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			port_we_d <= 1'b0;
			wr_valid  <= 1'b0;
			lmpr      <= 8'h00;
			hmpr      <= 8'h00;
			brdr      <= 8'h00;
			ext_c     <= 8'h00;
			ext_d     <= 8'h00;
		end else begin
			port_we_d <= port_we;
			wr_valid  <= wr_edge;
			if (wr_edge) begin
				case (sel)
					LMPR:    lmpr  <= bus.dout;
					HMPR:    hmpr  <= bus.dout;
					BORDER:  brdr  <= bus.dout;
					EXT_C:   ext_c <= bus.dout;
					EXT_D:   ext_d <= bus.dout;
					default: ;
				endcase
			end
		end
	end

	// Event payload, only looked at while wr_valid is set
	always_ff @(posedge clk_sys) begin
		if (wr_edge) begin
			wr_sel  <= sel;
			wr_data <= bus.dout;
		end
	end

	assign io_wr = '{valid: wr_valid, sel: wr_sel, data: wr_data};

	assign pages.page_ab  = lmpr[4:0];
	assign pages.rom0_off = lmpr[5];   // ROM0 on while bit 5 is low
	assign pages.rom1_on  = lmpr[6];
	assign pages.wp_a     = lmpr[7];
	assign pages.page_cd  = hmpr[4:0];
	assign pages.ext_on   = hmpr[7];
	assign pages.ext_c    = ext_c;
	assign pages.ext_d    = ext_d;

	assign beep = brdr[4];

	// ======================================================
	// Read-back
	// ======================================================
	always_comb begin
		readable = 1'b1;
		case (sel)
			STATUS:     io_dout = {3'b111, ~midi_int, 4'hF};
			LMPR:       io_dout = lmpr;
			HMPR:       io_dout = hmpr;
			LPT_DATA,
			LPT_STROBE: io_dout = 8'h00;    // No printer attached
			default: begin
				io_dout  = 8'hFF;
				readable = 1'b0;
			end
		endcase
	end

	assign io_dout_en = port_rd & readable;

endmodule

// File: mem_mapper.sv
// ==========================================================
// CPU address to physical memory request, purely combinational
// ROM sits at page 0x10, ROM0 and ROM1 share it by address bit 15
// Write protect covers section A only
// ==========================================================

`timescale 1ns/1ps

module mem_mapper import sam_pkg::*; (
	input  cpu_bus_t    bus,
	input  page_state_t pages,
	output mem_req_t    mem
);

	logic [1:0]        sect;
	logic              rom_sel;
	logic              ext_sel;
	logic              wp_hit;
	logic [8:0]        ext_page;
	logic [PAGE_W-1:0] base_page;
	logic [PAGE_W-1:0] ram_page;
	logic [TOP_W-1:0]  top;

	assign sect = bus.addr[15:14];

	// Overlay and window selects
	assign rom_sel = (~pages.rom0_off & (sect == 2'd0)) | (pages.rom1_on & (sect == 2'd3));
	assign ext_sel = pages.ext_on & bus.addr[15];
	assign wp_hit  = pages.wp_a & (sect == 2'd0);

	assign ext_page = EXT_RAM_BASE + {1'b0, (bus.addr[14] ? pages.ext_d : pages.ext_c)};

	// Odd sections take the following page, wraps at 32
	assign base_page = sect[1] ? pages.page_cd : pages.page_ab;
	assign ram_page  = base_page + PAGE_W'(sect[0]);

	always_comb begin
		if (rom_sel)
			top = TOP_W'({ROM_PAGE, bus.addr[15]});
		else if (ext_sel)
			top = TOP_W'(ext_page);
		else
			top = TOP_W'(ram_page);
	end

	assign mem.addr   = {top, bus.addr[SECT_W-1:0]};
	assign mem.rd     = bus.mreq & bus.rd;
	assign mem.we     = bus.mreq & bus.wr & ~rom_sel & ~wp_hit;
	assign mem.is_rom = rom_sel;

endmodule

// File: midi_tx.sv
// ==========================================================
// MIDI output timing model, no serial data is produced
// One byte takes 320 ticks of the 1 MHz enable
// Only one byte can wait behind the one in flight
// ==========================================================

`timescale 1ns/1ps

module midi_tx import sam_pkg::*; (
	input  logic   clk_sys,
	input  logic   reset,
	input  io_wr_t io_wr,
	output logic   midi_int,
	output logic   midi_busy
);

	logic [CE_1M_W-1:0]      tick_div;
	logic                    tick;
	logic [MIDI_TIMER_W-1:0] tx_time;
	logic                    pending;

	assign tick = (tick_div == CE_1M_W'(CE_1M_DIV - 1));

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			tick_div  <= '0;
			tx_time   <= '0;
			pending   <= 1'b0;
			midi_busy <= 1'b0;
			midi_int  <= 1'b0;
		end else begin
			tick_div <= tick ? '0 : tick_div + 1'b1;   // Free running 1 MHz

			if (tick) begin
				if (tx_time != '0) begin
					tx_time <= tx_time - 1'b1;
					if (tx_time == MIDI_TIMER_W'(MIDI_INT_TICK))
						midi_int <= 1'b1;
				end else begin
					// Frame done, start the queued byte if any
					midi_int  <= 1'b0;
					midi_busy <= 1'b0;
					if (pending) begin
						midi_busy <= 1'b1;
						tx_time   <= MIDI_TIMER_W'(MIDI_FRAME_TICKS - 1);
						pending   <= 1'b0;
					end
				end
			end

			// Late in the block so a write on a start tick is not lost
			if (io_wr.valid && io_wr.sel == MIDI)
				pending <= 1'b1;
		end
	end

endmodule

// File: audio_out.sv
// ==========================================================
// Printer port sample DAC and beeper mix
// Strobe bit 0 rising loads left, falling loads right
// Full scale mix stays below 2^19
// ==========================================================

`timescale 1ns/1ps

module audio_out import sam_pkg::*; (
	input  logic   clk_sys,
	input  logic   reset,
	input  io_wr_t io_wr,
	input  logic   beep,
	output logic   audio_l,
	output logic   audio_r
);

	logic [7:0]       lpt_data;
	logic             old_stb;
	logic [7:0]       vox_l;
	logic [7:0]       vox_r;
	logic [DAC_W-1:0] mix_l;
	logic [DAC_W-1:0] mix_r;

	function automatic logic [DAC_W-1:0] mix_sample(input logic [7:0] vox, input logic bit_in);
		logic [DAC_W-1:0] beep_part;
		beep_part = bit_in ? DAC_W'(BEEP_WEIGHT) : '0;
		return DAC_W'(vox) * DAC_W'(VOX_GAIN) + beep_part;
	endfunction

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			lpt_data <= 8'h00;
			old_stb  <= 1'b0;
			vox_l    <= 8'h00;
			vox_r    <= 8'h00;
		end else if (io_wr.valid) begin
			if (io_wr.sel == LPT_DATA)
				lpt_data <= io_wr.data;
			if (io_wr.sel == LPT_STROBE) begin
				if (~old_stb & io_wr.data[0]) vox_l <= lpt_data;  // Rising
				if (old_stb & ~io_wr.data[0]) vox_r <= lpt_data;  // Falling
				old_stb <= io_wr.data[0];
			end
		end
	end

	assign mix_l = mix_sample(vox_l, beep);
	assign mix_r = mix_sample(vox_r, beep);

	// ======================================================
	// Output modulators
	// ======================================================
	sigma_delta_dac #(.WIDTH(DAC_W)) dac_l (
		.clk_sys (clk_sys),
		.reset   (reset),
		.sample  (mix_l),
		.dac_out (audio_l)
	);

	sigma_delta_dac #(.WIDTH(DAC_W)) dac_r (
		.clk_sys (clk_sys),
		.reset   (reset),
		.sample  (mix_r),
		.dac_out (audio_r)
	);

endmodule

// File: sam_asic.sv
// ==========================================================
// SAM ASIC core, I/O ports, paging, MIDI timing and audio
// CPU strobes come in active high, one clock domain
// int_n carries only the MIDI interrupt
// ==========================================================

`timescale 1ns/1ps

module sam_asic import sam_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  cpu_bus_t   bus,
	output mem_req_t   mem,
	output logic [7:0] io_dout,
	output logic       io_dout_en,
	output logic       int_n,
	output logic       audio_l,
	output logic       audio_r
);

	io_wr_t      io_wr;
	page_state_t pages;
	logic        beep;
	logic        midi_int;

	port_regs regs0 (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.bus        (bus),
		.midi_int   (midi_int),
		.io_wr      (io_wr),
		.pages      (pages),
		.beep       (beep),
		.io_dout    (io_dout),
		.io_dout_en (io_dout_en)
	);

	mem_mapper map0 (
		.bus   (bus),
		.pages (pages),
		.mem   (mem)
	);

	midi_tx midi0 (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.io_wr     (io_wr),
		.midi_int  (midi_int),
		.midi_busy ()          // No serial line in this core
	);

	audio_out audio0 (
		.clk_sys (clk_sys),
		.reset   (reset),
		.io_wr   (io_wr),
		.beep    (beep),
		.audio_l (audio_l),
		.audio_r (audio_r)
	);

	assign int_n = ~midi_int;

endmodule

// File: tb_clk_gen.sv
// ==========================================================
// Testbench clock and reset source
// Reset is released on a falling edge after RESET_CYCLES
// ==========================================================

`timescale 1ns/1ps

module tb_clk_gen #(
	parameter int PERIOD_NS    = 8,
	parameter int RESET_CYCLES = 2
) (
	output logic clk_sys,
	output logic reset
);

	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD_NS / 2) clk_sys = ~clk_sys;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;   // Inputs change on falling edges only
	end

endmodule

// File: tb_sam_asic.sv
// ==========================================================
// Directed tests for the SAM ASIC core
// Bus driven and outputs sampled on falling edges
// Each DAC check runs a full 2^19 clock window
// ==========================================================

`timescale 1ns/1ps

module tb_sam_asic import sam_pkg::*; ();

	localparam int     CLK_PERIOD  = 8;
	localparam int     SEED        = 42573;
	localparam int     DAC_WINDOW  = 1 << 19;
	localparam longint FALL_LIMIT  = (320 - 15 + 2) * 96;
	localparam longint RISE_LIMIT  = 322 * 96;
	localparam longint EARLY_LIMIT = 304 * 96;   // Interrupt cannot come sooner
	// Two DAC windows, five MIDI frame waits, plus slack for bus cycles
	localparam longint RUN_CLKS    = 2 * DAC_WINDOW + 5 * RISE_LIMIT + 20000;
	localparam longint WATCHDOG_NS = RUN_CLKS * CLK_PERIOD;

	logic       clk_sys;
	logic       reset;
	cpu_bus_t   bus;
	mem_req_t   mem;
	logic [7:0] io_dout;
	logic       io_dout_en;
	logic       int_n;
	logic       audio_l;
	logic       audio_r;

	longint cycle = 0;
	int     test_errs = 0;
	int     total_errs = 0;
	int     tests_run = 0;
	int     tests_failed = 0;

	tb_clk_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(2)) clk0 (
		.clk_sys (clk_sys),
		.reset   (reset)
	);

	sam_asic dut0 (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.bus        (bus),
		.mem        (mem),
		.io_dout    (io_dout),
		.io_dout_en (io_dout_en),
		.int_n      (int_n),
		.audio_l    (audio_l),
		.audio_r    (audio_r)
	);

	always @(posedge clk_sys) cycle <= cycle + 1;

	// ======================================================
	// Reference model of the memory map
	// ======================================================
	function automatic logic rom_ref(input logic [15:0] a, input logic [7:0] lm);
		return (~lm[5] & (a[15:14] == 2'd0)) | (lm[6] & (a[15:14] == 2'd3));
	endfunction

	function automatic logic [24:0] map_ref(input logic [15:0] a, input logic [7:0] lm,
			input logic [7:0] hm, input logic [7:0] ec, input logic [7:0] ed);
		logic [10:0] top;
		logic [4:0]  pg;
		if (rom_ref(a, lm)) begin
			top = {5'b0, 5'h10, a[15]};
		end else if (hm[7] & a[15]) begin
			top = {2'b0, 9'h040 + {1'b0, (a[15:14] == 2'd2) ? ec : ed}};
		end else begin
			pg  = a[15] ? hm[4:0] : lm[4:0];
			pg  = pg + {4'b0, a[14]};   // Odd section uses the next page
			top = {6'b0, pg};
		end
		return {top, a[13:0]};
	endfunction

	function automatic int abs_diff(input int a, input int b);
		return (a > b) ? a - b : b - a;
	endfunction

	// ======================================================
	// Reporting
	// ======================================================
	task automatic report_mismatch(input string sig, input logic [31:0] got,
			input logic [31:0] exp);
		$display("ERROR %0t: %s is 0x%0h, expected 0x%0h", $time, sig, got, exp);
		test_errs++;
	endtask

	task automatic note_failure(input string what);
		$display("At %0t: %s", $time, what);
		test_errs++;
	endtask

	task automatic check_mem(input mem_req_t r, input logic [24:0] exp_addr,
			input logic exp_we, input logic exp_rd, input logic exp_rom);
		if (r.addr !== exp_addr) report_mismatch("mem.addr", 32'(r.addr), 32'(exp_addr));
		if (r.we !== exp_we) report_mismatch("mem.we", 32'(r.we), 32'(exp_we));
		if (r.rd !== exp_rd) report_mismatch("mem.rd", 32'(r.rd), 32'(exp_rd));
		if (r.is_rom !== exp_rom) report_mismatch("mem.is_rom", 32'(r.is_rom), 32'(exp_rom));
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		total_errs += test_errs;
		if (test_errs != 0)
			tests_failed++;
		$display("%s: %s, %0d errors", name, (test_errs == 0) ? "ok" : "failed", test_errs);
		test_errs = 0;
	endtask

	// ======================================================
	// Bus cycles with strobes held for 3 clocks
	// ======================================================
	task automatic io_write(input logic [7:0] port, input logic [7:0] data);
		@(negedge clk_sys);
		bus.addr = {8'h00, port};
		bus.dout = data;
		bus.iorq = 1'b1;
		bus.wr   = 1'b1;
		repeat (3) @(negedge clk_sys);
		bus.iorq = 1'b0;
		bus.wr   = 1'b0;
	endtask

	task automatic io_read(input logic [7:0] port, output logic [7:0] data, output logic en);
		@(negedge clk_sys);
		bus.addr = {8'h00, port};
		bus.iorq = 1'b1;
		bus.rd   = 1'b1;
		@(negedge clk_sys);
		data = io_dout;
		en   = io_dout_en;
		repeat (2) @(negedge clk_sys);
		bus.iorq = 1'b0;
		bus.rd   = 1'b0;
	endtask

	task automatic mem_access(input logic [15:0] a, input logic write, output mem_req_t r);
		@(negedge clk_sys);
		bus.addr = a;
		bus.mreq = 1'b1;
		bus.wr   = write;
		bus.rd   = ~write;
		@(negedge clk_sys);
		r = mem;
		repeat (2) @(negedge clk_sys);
		bus.mreq = 1'b0;
		bus.wr   = 1'b0;
		bus.rd   = 1'b0;
	endtask

	task automatic wait_int_n(input logic level, input longint start, input longint limit,
			output bit seen);
		while (int_n !== level && (cycle - start) <= limit)
			@(negedge clk_sys);
		seen = (int_n === level);
	endtask

	task automatic count_ones(output int cl, output int cr);
		cl = 0;
		cr = 0;
		repeat (DAC_WINDOW) begin
			@(negedge clk_sys);
			if (audio_l)
				cl++;
			if (audio_r)
				cr++;
		end
	endtask

	// ======================================================
	// Tests
	// ======================================================
	task automatic reset_state();
		mem_req_t   r;
		logic [7:0] d;
		logic       en;
		if (int_n !== 1'b1) report_mismatch("int_n", 32'(int_n), 32'h1);
		if (io_dout_en !== 1'b0) report_mismatch("io_dout_en", 32'(io_dout_en), 32'h0);
		mem_access(16'h0123, 1'b1, r);
		check_mem(r, map_ref(16'h0123, 8'h00, 8'h00, 8'h00, 8'h00), 1'b0, 1'b0, 1'b1);
		io_read(PORT_STATUS, d, en);
		if (d !== 8'hFF) report_mismatch("io_dout", 32'(d), 32'hFF);
		if (en !== 1'b1) report_mismatch("io_dout_en", 32'(en), 32'h1);
		finish_test("reset_state");
	endtask

	task automatic register_read_back();
		logic [7:0] lm;
		logic [7:0] hm;
		logic [7:0] d;
		logic       en;
		lm = 8'($urandom());
		hm = 8'($urandom());
		io_write(PORT_LMPR, lm);
		io_write(PORT_HMPR, hm);
		io_read(PORT_LMPR, d, en);
		if (d !== lm) report_mismatch("io_dout", 32'(d), 32'(lm));
		if (en !== 1'b1) report_mismatch("io_dout_en", 32'(en), 32'h1);
		io_read(PORT_HMPR, d, en);
		if (d !== hm) report_mismatch("io_dout", 32'(d), 32'(hm));
		if (en !== 1'b1) report_mismatch("io_dout_en", 32'(en), 32'h1);
		io_read(8'h10, d, en);   // Nothing decoded here
		if (d !== 8'hFF) report_mismatch("io_dout", 32'(d), 32'hFF);
		if (en !== 1'b0) report_mismatch("io_dout_en", 32'(en), 32'h0);
		finish_test("register_read_back");
	endtask

	task automatic paging();
		logic [7:0]  lm;
		logic [7:0]  hm;
		logic [7:0]  ec;
		logic [7:0]  ed;
		logic [15:0] a;
		logic [24:0] exp_addr;
		logic        exp_rom;
		logic        exp_we;
		mem_req_t    r;
		for (int cfg = 0; cfg < 10; cfg++) begin
			lm = 8'($urandom());
			hm = 8'($urandom());
			ec = 8'($urandom());
			ed = 8'($urandom());
			if (cfg == 0) begin
				lm[7:5] = 3'b111;   // WP on, ROM1 on, ROM0 off
				hm[7]   = 1'b1;
			end else if (cfg == 1) begin
				lm[7:5] = 3'b001;   // RAM low, ext window high
				hm[7]   = 1'b1;
			end else if (cfg == 2) begin
				lm[7:5] = 3'b001;
				hm[7]   = 1'b0;
			end
			io_write(PORT_LMPR, lm);
			io_write(PORT_HMPR, hm);
			io_write(PORT_EXT_C, ec);
			io_write(PORT_EXT_D, ed);
			for (int s = 0; s < 4; s++) begin
				a        = {2'(s), 14'($urandom())};
				exp_rom  = rom_ref(a, lm);
				exp_addr = map_ref(a, lm, hm, ec, ed);
				exp_we   = ~exp_rom & ~(lm[7] & (a[15:14] == 2'd0));
				mem_access(a, 1'b1, r);
				check_mem(r, exp_addr, exp_we, 1'b0, exp_rom);
				mem_access(a, 1'b0, r);   // Read of the same address
				check_mem(r, exp_addr, 1'b0, 1'b1, exp_rom);
			end
		end
		finish_test("paging");
	endtask

	task automatic midi_timing();
		longint     t0;
		logic [7:0] d;
		logic       en;
		bit         seen;
		io_write(PORT_MIDI, 8'h90);
		t0 = cycle;
		wait_int_n(1'b0, t0, FALL_LIMIT, seen);
		if (!seen)
			note_failure("MIDI interrupt never came for the first byte");
		else if (cycle - t0 < EARLY_LIMIT)
			note_failure("MIDI interrupt came before the frame was near its end");
		io_read(PORT_STATUS, d, en);
		if (d !== 8'hEF) report_mismatch("io_dout", 32'(d), 32'hEF);
		io_write(PORT_MIDI, 8'h45);   // Queued behind the busy frame
		wait_int_n(1'b1, t0, RISE_LIMIT, seen);
		if (!seen)
			note_failure("MIDI interrupt stayed pending past the end of the frame");
		t0 = cycle;
		wait_int_n(1'b0, t0, FALL_LIMIT, seen);
		if (!seen)
			note_failure("queued MIDI byte raised no interrupt");
		wait_int_n(1'b1, t0, RISE_LIMIT, seen);
		if (!seen)
			note_failure("second MIDI interrupt did not clear");
		t0 = cycle;
		wait_int_n(1'b0, t0, RISE_LIMIT, seen);
		if (seen)
			note_failure("extra MIDI interrupt with no byte queued");
		finish_test("midi_timing");
	endtask

	task automatic audio_mix();
		logic [7:0] vl;
		logic [7:0] vr;
		int         cl;
		int         cr;
		int         exp_l;
		int         exp_r;
		vl = 8'($urandom());
		vr = 8'($urandom());
		io_write(PORT_LPT_DATA, vl);
		io_write(PORT_LPT_STROBE, 8'h01);   // Rising edge loads left
		io_write(PORT_LPT_DATA, vr);
		io_write(PORT_LPT_STROBE, 8'h00);   // Falling edge loads right
		repeat (2) @(negedge clk_sys);
		count_ones(cl, cr);
		exp_l = int'(vl) * 1028;
		exp_r = int'(vr) * 1028;
		if (cl != exp_l) report_mismatch("audio_l ones", 32'(cl), 32'(exp_l));
		if (cr != exp_r) report_mismatch("audio_r ones", 32'(cr), 32'(exp_r));

		io_write(PORT_BORDER, 8'h10);   // Beeper bit on
		repeat (2) @(negedge clk_sys);
		count_ones(cl, cr);
		exp_l = exp_l + 65536;
		exp_r = exp_r + 65536;
		if (abs_diff(cl, exp_l) > 2) report_mismatch("audio_l ones", 32'(cl), 32'(exp_l));
		if (abs_diff(cr, exp_r) > 2) report_mismatch("audio_r ones", 32'(cr), 32'(exp_r));
		finish_test("audio_mix");
	endtask

	// ======================================================
	// Sequence and watchdog
	// ======================================================
	initial begin
		bus = '0;
		void'($urandom(SEED));
		while (reset !== 1'b0)
			@(negedge clk_sys);
		reset_state();
		register_read_back();
		paging();
		midi_timing();
		audio_mix();
		$display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
			total_errs);
		if (total_errs == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
		$display("TEST FAIL");
		$finish;
	end

endmodule

// File: project.f
sam_pkg.sv
sigma_delta_dac.sv
port_regs.sv
mem_mapper.sv
midi_tx.sv
audio_out.sv
sam_asic.sv
tb_clk_gen.sv
tb_sam_asic.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the SAM ASIC testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_sam_asic -f project.f -o tb_sam_asic_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/tb_sam_asic_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "TEST PASS" sim.log; then
	exit 0
fi
echo "Pass line not found in sim.log"
exit 1
